// File: flist.f
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_data_mem.sv
rv_core_top.sv
tb_rv_core.sv

// File: rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top #(
  parameter rv_pkg::word_t reset_pc = 32'h0000_3000,
  parameter int            mem_aw   = 8
) (
  input  logic        clk_cpu,
  input  logic        rstn,
  input  logic        debug,
  input  logic        we_im,
  input  logic        we_dm,
  input  logic [31:0] addr,
  input  logic [31:0] din,
  output logic [31:0] pc,
  output logic [31:0] dout_rf,
  output logic [31:0] dout_im,
  output logic [31:0] dout_dm
);
  import rv_pkg::*;

  dbg_req_t dbg;
  word_t    instr;
  decoded_t dec;
  exec_t    ex;
  word_t    rs1_val;
  word_t    rs2_val;
  logic     wb_we;
  reg_idx_t wb_rd;
  word_t    wb_data;

  assign dbg = '{debug: debug, we_im: we_im, we_dm: we_dm, addr: addr, din: din};

  rv_fetch #(
    .reset_pc (reset_pc),
    .mem_aw   (mem_aw)
  ) u_fetch (
    .clk_cpu  (clk_cpu),
    .rstn     (rstn),
    .dbg      (dbg),
    .ex       (ex),
    .pc       (pc),
    .instr    (instr),
    .dout_im  (dout_im)
  );

  rv_decode u_decode (
    .instr (instr),
    .dec   (dec)
  );

  rv_regfile u_regfile (
    .clk_cpu  (clk_cpu),
    .rstn     (rstn),
    .dbg      (dbg),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .wb_we    (wb_we),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data),
    .rs1_val  (rs1_val),
    .rs2_val  (rs2_val),
    .dout_rf  (dout_rf)
  );

  rv_execute u_execute (
    .pc       (pc),
    .rs1_val  (rs1_val),
    .rs2_val  (rs2_val),
    .dec      (dec),
    .ex       (ex)
  );

  rv_data_mem #(
    .mem_aw (mem_aw)
  ) u_data_mem (
    .clk_cpu  (clk_cpu),
    .dbg      (dbg),
    .dec      (dec),
    .ex       (ex),
    .wb_we    (wb_we),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data),
    .dout_dm  (dout_dm)
  );

endmodule

// File: rv_data_mem.sv
`timescale 1ns/1ps

module rv_data_mem #(
  parameter int mem_aw = 8
) (
  input  logic             clk_cpu,
  input  rv_pkg::dbg_req_t dbg,
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::exec_t    ex,
  output logic             wb_we,
  output rv_pkg::reg_idx_t wb_rd,
  output rv_pkg::word_t    wb_data,
  output rv_pkg::word_t    dout_dm
);
  import rv_pkg::*;

  word_t             dmem [0:2**mem_aw-1];
  logic [mem_aw-1:0] core_idx;
  logic [mem_aw-1:0] dbg_idx;
  logic [mem_aw-1:0] wr_idx;
  logic              core_we;
  logic              wr_en;
  word_t             wr_data;
  word_t             load_data;

  assign core_idx = ex.mem_addr[mem_aw+1:2];
  assign dbg_idx  = dbg.addr[mem_aw+1:2];
  assign core_we  = (dec.op == op_sw) && !dbg.debug;

  // one write port, shared between core and debug
  assign wr_en   = dbg.debug ? dbg.we_dm : core_we;
  assign wr_idx  = dbg.debug ? dbg_idx : core_idx;
  assign wr_data = dbg.debug ? dbg.din : ex.store_data;

  always_ff @(posedge clk_cpu) begin
    if (wr_en) begin
      dmem[wr_idx] <= wr_data;
    end
  end

  assign load_data = dmem[core_idx];
  assign dout_dm   = dbg.debug ? dmem[dbg_idx] : '0;

  always_comb begin
    case (dec.op)
      op_add, op_sub, op_addi, op_slli, op_lw, op_auipc, op_jal: begin
        wb_we = !dbg.debug;
      end
      default: wb_we = 1'b0;
    endcase
  end

  assign wb_rd   = dec.rd;
  assign wb_data = (dec.op == op_lw) ? load_data : ex.result;

  // word at the core's store address must survive a debug cycle without we_dm
  a_no_core_store: assert property (
    @(posedge clk_cpu)
    (dbg.debug && !dbg.we_dm) |=> dmem[$past(core_idx)] === $past(dmem[core_idx])
  ) else $error("core store landed while debug high");

endmodule

// File: rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
  input  rv_pkg::word_t    instr,
  output rv_pkg::decoded_t dec
);
  import rv_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  reg_idx_t   rs1_f;
  reg_idx_t   rs2_f;
  reg_idx_t   rd_f;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  word_t      imm_sh;

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign rs1_f  = instr[19:15];
  assign rs2_f  = instr[24:20];
  assign rd_f   = instr[11:7];

  assign imm_i  = {{20{instr[31]}}, instr[31:20]};
  assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u  = {instr[31:12], 12'h000};
  assign imm_j  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_sh = {27'd0, instr[24:20]}; // shamt, zero extended

  always_comb begin
    dec = '0; // op_nop, no reads, no write
    case (opcode)
      opc_reg: begin
        dec.op  = instr[30] ? op_sub : op_add;
        dec.rs1 = rs1_f;
        dec.rs2 = rs2_f;
        dec.rd  = rd_f;
      end
      opc_imm: begin
        if (funct3 == 3'b000) begin
          dec.op  = op_addi;
          dec.rs1 = rs1_f;
          dec.rd  = rd_f;
          dec.imm = imm_i;
        end else if (funct3 == 3'b001) begin
          dec.op  = op_slli;
          dec.rs1 = rs1_f;
          dec.rd  = rd_f;
          dec.imm = imm_sh;
        end
      end
      opc_load: begin
        dec.op  = op_lw;
        dec.rs1 = rs1_f;
        dec.rd  = rd_f;
        dec.imm = imm_i;
      end
      opc_store: begin
        dec.op  = op_sw;
        dec.rs1 = rs1_f;
        dec.rs2 = rs2_f;
        dec.imm = imm_s;
      end
      opc_branch: begin
        if (funct3 == 3'b000 || funct3 == 3'b110) begin
          dec.op  = (funct3 == 3'b000) ? op_beq : op_bltu;
          dec.rs1 = rs1_f;
          dec.rs2 = rs2_f;
          dec.imm = imm_b;
        end
      end
      opc_auipc: begin
        dec.op  = op_auipc;
        dec.rd  = rd_f;
        dec.imm = imm_u;
      end
      opc_jal: begin
        dec.op  = op_jal;
        dec.rd  = rd_f;
        dec.imm = imm_j;
      end
      default: dec = '0; // unknown opcode
    endcase
  end

endmodule

// File: rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
  input  rv_pkg::word_t    pc,
  input  rv_pkg::word_t    rs1_val,
  input  rv_pkg::word_t    rs2_val,
  input  rv_pkg::decoded_t dec,
  output rv_pkg::exec_t    ex
);
  import rv_pkg::*;

  word_t sum_imm;
  word_t pc_rel;
  word_t pc_plus4;
  logic  eq;
  logic  ltu;

  assign sum_imm  = rs1_val + dec.imm; // addi and lw/sw address
  assign pc_rel   = pc + dec.imm;
  assign pc_plus4 = pc + 32'd4;
  assign eq       = (rs1_val == rs2_val);
  assign ltu      = (rs1_val < rs2_val); // unsigned compare

  always_comb begin
    ex             = '0;
    ex.mem_addr    = sum_imm;
    ex.store_data  = rs2_val;
    ex.target      = pc_rel;
    case (dec.op)
      op_add: ex.result = rs1_val + rs2_val;
      op_sub: ex.result = rs1_val - rs2_val;
      op_addi, op_lw, op_sw: begin
        ex.result = sum_imm;
      end
      op_slli: ex.result = rs1_val << dec.imm[4:0];
      op_auipc: ex.result = pc_rel;
      op_jal: begin
        ex.result      = pc_plus4; // link
        ex.take_branch = 1'b1;
      end
      op_beq: ex.take_branch = eq;
      op_bltu: ex.take_branch = ltu;
      default: ex.result = '0;
    endcase
  end

endmodule

// File: rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch #(
  parameter rv_pkg::word_t reset_pc = 32'h0000_3000,
  parameter int            mem_aw   = 8
) (
  input  logic             clk_cpu,
  input  logic             rstn,
  input  rv_pkg::dbg_req_t dbg,
  input  rv_pkg::exec_t    ex,
  output rv_pkg::word_t    pc,
  output rv_pkg::word_t    instr,
  output rv_pkg::word_t    dout_im
);
  import rv_pkg::*;

  word_t             imem [0:2**mem_aw-1];
  word_t             npc;
  logic [mem_aw-1:0] pc_idx;
  logic [mem_aw-1:0] dbg_idx;

  assign pc_idx  = pc[mem_aw+1:2];
  assign dbg_idx = dbg.addr[mem_aw+1:2];

  assign npc = ex.take_branch ? ex.target : pc + 32'd4;

  always_ff @(posedge clk_cpu or negedge rstn) begin
    if (!rstn) begin
      pc <= reset_pc;
    end else if (!dbg.debug) begin // frozen in debug
      pc <= npc;
    end
  end

  // program load from outside
  always_ff @(posedge clk_cpu) begin
    if (dbg.debug && dbg.we_im) begin
      imem[dbg_idx] <= dbg.din;
    end
  end

  assign instr   = imem[pc_idx];
  assign dout_im = dbg.debug ? imem[dbg_idx] : '0;

  // branch and jump targets come from execute, so alignment is a system property
  a_pc_aligned: assert property (
    @(posedge clk_cpu) disable iff (!rstn)
    pc[1:0] == 2'b00
  ) else $error("pc not word aligned: %h", pc);

endmodule

// File: rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;

  typedef logic [4:0]      reg_idx_t;
  typedef logic [xlen-1:0] word_t;

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    opc_reg    = 7'b0110011,
    opc_imm    = 7'b0010011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111
  } opcode_e;

  // internal operations, same numbering as the old CTL word
  typedef enum logic [3:0] {
    op_nop   = 4'd0,
    op_add   = 4'd1,
    op_sub   = 4'd2,
    op_auipc = 4'd3,
    op_lw    = 4'd4,
    op_sw    = 4'd5,
    op_beq   = 4'd6,
    op_bltu  = 4'd7,
    op_jal   = 4'd8,
    op_slli  = 4'd9,
    op_addi  = 4'd10
  } op_e;

  typedef struct packed {
    logic  debug;       // core frozen, memories open to the outside
    logic  we_im;
    logic  we_dm;
    word_t addr;
    word_t din;
  } dbg_req_t;

  typedef struct packed {
    op_e      op;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;      // already extended
  } decoded_t;

  typedef struct packed {
    word_t result;      // alu or link value
    word_t mem_addr;
    word_t store_data;
    logic  take_branch;
    word_t target;
  } exec_t;

endpackage

// File: rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input  logic             clk_cpu,
  input  logic             rstn,
  input  rv_pkg::dbg_req_t dbg,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  logic             wb_we,
  input  rv_pkg::reg_idx_t wb_rd,
  input  rv_pkg::word_t    wb_data,
  output rv_pkg::word_t    rs1_val,
  output rv_pkg::word_t    rs2_val,
  output rv_pkg::word_t    dout_rf
);
  import rv_pkg::*;

  word_t regs [0:31];

  always_ff @(posedge clk_cpu or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we && !dbg.debug && wb_rd != 5'd0) begin // x0 never written
      regs[wb_rd] <= wb_data;
    end
  end

  assign rs1_val = regs[rs1];
  assign rs2_val = regs[rs2];
  assign dout_rf = dbg.debug ? regs[dbg.addr[4:0]] : '0;

  a_x0_zero: assert property (
    @(posedge clk_cpu) disable iff (!rstn)
    (rs1 == 5'd0 |-> rs1_val == '0) and (rs2 == 5'd0 |-> rs2_val == '0)
  ) else $error("x0 read back non-zero");

endmodule

// File: tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

  localparam logic [31:0] reset_pc = 32'h0000_3000;
  localparam int mem_aw = 8;
  localparam int depth = 2**mem_aw;
  localparam int prog_len = 40;
  localparam int rounds = 4;
  localparam int run_a = 20;
  localparam int run_b = 30;
  localparam int freeze_len = 3;
  localparam int round_cycles = 2 + 4*depth + run_a + freeze_len + run_b + 32;
  localparam int max_cycles = rounds*round_cycles + 100;

  logic        clk_cpu;
  logic        rstn;
  logic        debug;
  logic        we_im;
  logic        we_dm;
  logic [31:0] addr;
  logic [31:0] din;
  logic [31:0] pc;
  logic [31:0] dout_rf;
  logic [31:0] dout_im;
  logic [31:0] dout_dm;

  logic [31:0] rng = 32'd68;
  logic [31:0] m_pc;
  logic [31:0] m_regs [0:31];
  logic [31:0] m_imem [0:depth-1];
  logic [31:0] m_dmem [0:depth-1];
  int          cycles = 0;

  rv_core_top #(
    .reset_pc (reset_pc),
    .mem_aw   (mem_aw)
  ) uut (
    .clk_cpu (clk_cpu),
    .rstn    (rstn),
    .debug   (debug),
    .we_im   (we_im),
    .we_dm   (we_dm),
    .addr    (addr),
    .din     (din),
    .pc      (pc),
    .dout_rf (dout_rf),
    .dout_im (dout_im),
    .dout_dm (dout_dm)
  );

  initial begin
    clk_cpu = 1'b0;
    forever #10 clk_cpu = ~clk_cpu;
  end

  always @(posedge clk_cpu) begin
    cycles <= cycles + 1;
    if (cycles > max_cycles) begin
      $display("timeout: the run did not end within %0d cycles", max_cycles);
      $display("Test failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic int word_idx(input logic [31:0] a);
    return int'(a[mem_aw+1:2]);
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
      $display("Test failed");
      $fatal(1, "first mismatch ends the run");
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_cpu);
    #2;
  endtask

  // one random instruction at word pos, kinds limits the mix
  function automatic logic [31:0] gen_instr(input int pos, input int kinds);
    logic [31:0] r;
    logic [31:0] w;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  woff;
    logic [12:0] boff;
    logic [20:0] joff;
    int          maxk;
    int          kind;
    r = next_rand();
    rd = {2'b00, r[2:0]};
    rs1 = {2'b00, r[5:3]};
    rs2 = {2'b00, r[8:6]};
    woff = r[13:9];
    maxk = prog_len - 1 - pos; // forward only, never past the final jal
    if (maxk > 3) maxk = 3;
    boff = 4 * (1 + int'(next_rand() % maxk));
    joff = {8'd0, boff};
    kind = int'(next_rand() % kinds);
    case (kind)
      0: w = {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};              // add
      1: w = {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};              // sub
      2: w = {r[31:20], rs1, 3'b000, rd, 7'b0010011};                // addi
      3: w = {7'h00, r[24:20], rs1, 3'b001, rd, 7'b0010011};         // slli
      4: w = {r[31:12], rd, 7'b0010111};                             // auipc
      5: w = {5'd0, woff, 2'b00, 5'd0, 3'b010, rd, 7'b0000011};      // lw off(x0)
      6: w = {5'd0, woff[4:3], rs2, 5'd0, 3'b010, woff[2:0], 2'b00, 7'b0100011};
      7: w = {boff[12], boff[10:5], rs2, rs1, 3'b000, boff[4:1], boff[11], 7'b1100011};
      8: w = {boff[12], boff[10:5], rs2, rs1, 3'b110, boff[4:1], boff[11], 7'b1100011};
      9: w = {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111};
      10: w = {r[31:7], 7'b0001011};                                 // unknown opcode
      default: w = {r[31:20], rs1, 3'b111, rd, 7'b0010011};          // unknown funct3
    endcase
    return w;
  endfunction

  // reference model, one instruction
  task automatic model_step();
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic        wr;
    logic        taken;
    ins = m_imem[word_idx(m_pc)];
    opc = ins[6:0];
    f3 = ins[14:12];
    a = m_regs[ins[19:15]];
    b = m_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    case (opc)
      7'b0110011: val = ins[30] ? a - b : a + b;
      7'b0010011: val = (f3 == 3'b000) ? a + imm_i : a << ins[24:20];
      7'b0000011: val = m_dmem[word_idx(a + imm_i)];
      7'b0010111: val = m_pc + {ins[31:12], 12'h000};
      7'b1101111: val = m_pc + 32'd4;
      default: val = 32'd0;
    endcase
    wr = (opc == 7'b0110011) || (opc == 7'b0000011) || (opc == 7'b0010111) ||
         (opc == 7'b1101111) || (opc == 7'b0010011 && (f3 == 3'b000 || f3 == 3'b001));
    taken = (opc == 7'b1100011) && ((f3 == 3'b000 && a == b) || (f3 == 3'b110 && a < b));
    if (opc == 7'b0100011) m_dmem[word_idx(a + imm_s)] = b;
    if (wr && ins[11:7] != 5'd0) m_regs[ins[11:7]] = val;
    if (opc == 7'b1101111) m_pc = m_pc + imm_j;
    else if (taken) m_pc = m_pc + imm_b;
    else m_pc = m_pc + 32'd4;
  endtask

  task automatic apply_reset();
    rstn = 1'b0;
    debug = 1'b1;
    we_im = 1'b0;
    we_dm = 1'b0;
    repeat (2) next_cycle();
    rstn = 1'b1;
    m_pc = reset_pc;
    for (int r = 0; r < 32; r++) m_regs[r] = 32'd0;
  endtask

  task automatic load_memories(input int kinds);
    debug = 1'b1;
    for (int i = 0; i < 2*depth; i++) begin
      we_im = (i < depth);
      we_dm = (i >= depth);
      addr = (i % depth) * 4;
      if (i >= depth) m_dmem[i-depth] = next_rand();
      else if (i == prog_len - 1) m_imem[i] = 32'h0000_006f; // jal x0, 0
      else if (i < prog_len - 1) m_imem[i] = gen_instr(i, kinds);
      else m_imem[i] = next_rand();
      din = (i < depth) ? m_imem[i] : m_dmem[i-depth];
      @(negedge clk_cpu);
      check("pc", m_pc, pc); // frozen during load
      next_cycle();
    end
    we_im = 1'b0;
    we_dm = 1'b0;
  endtask

  task automatic read_memories();
    debug = 1'b1;
    for (int i = 0; i < depth; i++) begin
      addr = i * 4;
      @(negedge clk_cpu);
      check("dout_im", m_imem[i], dout_im);
      check("dout_dm", m_dmem[i], dout_dm);
      next_cycle();
    end
  endtask

  task automatic read_registers();
    debug = 1'b1;
    check("final pc", reset_pc + 4*(prog_len-1), pc);
    for (int r = 0; r < 32; r++) begin
      addr = r;
      @(negedge clk_cpu);
      check($sformatf("dout_rf x%0d", r), m_regs[r], dout_rf);
      next_cycle();
    end
  endtask

  task automatic run_core(input int n);
    debug = 1'b0;
    for (int c = 0; c < n; c++) begin
      addr = next_rand() & 32'h0000_03fc; // debug reads must stay 0
      @(negedge clk_cpu);
      check("pc", m_pc, pc);
      check("dout_rf", 32'd0, dout_rf);
      check("dout_im", 32'd0, dout_im);
      check("dout_dm", 32'd0, dout_dm);
      model_step();
      next_cycle();
    end
  endtask

  task automatic freeze_core(input int n);
    debug = 1'b1;
    for (int c = 0; c < n; c++) begin
      addr = next_rand() % 8;
      @(negedge clk_cpu);
      check("pc", m_pc, pc);
      check("dout_rf", m_regs[addr[4:0]], dout_rf);
      next_cycle();
    end
  endtask

  initial begin
    rstn = 1'b0;
    debug = 1'b1;
    we_im = 1'b0;
    we_dm = 1'b0;
    addr = 32'd0;
    din = 32'd0;
    for (int r = 0; r < rounds; r++) begin
      apply_reset();
      load_memories(r == 0 ? 5 : (r == 1 ? 7 : 12)); // arith, then memory, then all
      read_memories();
      run_core(run_a);
      freeze_core(freeze_len);
      run_core(run_b);
      read_registers();
      read_memories();
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule
